// ==== Makefile ====
TOP := binner_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f vlog.f --top-module binner_top

obj_dir/V$(TOP): vlog.f logic/*.sv logic/*.svh tests/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module $(TOP)

# pass only if the run printed the pass message
sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== logic/binner_cfg.svh ====
/*
 * Width and size defines for the tile binner
 * edge count, coordinate, coefficient, edge value and shift widths
 */
`ifndef BINNER_CFG_SVH
`define BINNER_CFG_SVH

// three edges per triangle
`define BINNER_EDGE_N 3

// tile index and pixel coordinate
`define BINNER_COORD_W 16

// a and b coefficients, signed
`define BINNER_COEF_W 16

// c term, signed
`define BINNER_CONST_W 32

// a*x + b*y + c with corners up to 17 bits, room to spare
`define BINNER_EVAL_W 40

// log2 of the tile size in pixels
`define BINNER_SHIFT_W 4

`endif

// ==== logic/binner_ctl_pkg.sv ====
/*
 * Control enums for the binner
 * walker FSM states and tile classes
 */
package binner_ctl_pkg;

    // walker FSM
    typedef enum logic [1:0] {
        W_IDLE  = 2'd0,
        W_STEP  = 2'd1,
        W_DRAIN = 2'd2
    } walk_state_e;

    // outcome of the TR/TA tests for one tile
    typedef enum logic [1:0] {
        TC_REJECT  = 2'd0,
        TC_PARTIAL = 2'd1,
        TC_FULL    = 2'd2
    } tile_class_e;

endpackage

// ==== logic/binner_top.sv ====
/*
 * binner_top: tile walker, TR and TA corner evaluators, classifier
 */
`include "binner_cfg.svh"

module binner_top (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_valid,
    input  raster_geom_pkg::coef_t   i_edge_a [`BINNER_EDGE_N],
    input  raster_geom_pkg::coef_t   i_edge_b [`BINNER_EDGE_N],
    input  raster_geom_pkg::const_t  i_edge_c [`BINNER_EDGE_N],
    input  raster_geom_pkg::coord_t  i_min_tx,
    input  raster_geom_pkg::coord_t  i_min_ty,
    input  raster_geom_pkg::coord_t  i_tiles_x,
    input  raster_geom_pkg::coord_t  i_tiles_y,
    input  raster_geom_pkg::shift_t  i_tile_shift,
    input  logic                     i_raster_full,
    input  logic                     i_shader_full,
    output logic                     o_busy,
    output logic                     o_raster_write,
    output logic                     o_shader_write,
    output raster_geom_pkg::coord_t  o_tile_x,
    output raster_geom_pkg::coord_t  o_tile_y
);

    logic                        w_stall;
    logic                        w_walk_busy;
    logic                        w_tile_valid;
    raster_geom_pkg::coord_t     w_tile_x;
    raster_geom_pkg::coord_t     w_tile_y;
    raster_geom_pkg::coord_t     w_px;
    raster_geom_pkg::coord_t     w_py;
    raster_geom_pkg::coef_t      w_edge_a [`BINNER_EDGE_N];
    raster_geom_pkg::coef_t      w_edge_b [`BINNER_EDGE_N];
    raster_geom_pkg::const_t     w_edge_c [`BINNER_EDGE_N];
    raster_geom_pkg::shift_t     w_tile_shift;
    logic                        w_tr_valid;
    raster_geom_pkg::coord_t     w_tr_tile_x;
    raster_geom_pkg::coord_t     w_tr_tile_y;
    raster_geom_pkg::eval_t      w_tr_value [`BINNER_EDGE_N];
    raster_geom_pkg::eval_t      w_ta_value [`BINNER_EDGE_N];
    binner_ctl_pkg::walk_state_e w_walk_state;

    // walker FSM state for waveforms
    assign w_walk_state = walker_i.r_state;

    tile_walker walker_i (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_stall      (w_stall),
        .i_valid      (i_valid),
        .i_edge_a     (i_edge_a),
        .i_edge_b     (i_edge_b),
        .i_edge_c     (i_edge_c),
        .i_min_tx     (i_min_tx),
        .i_min_ty     (i_min_ty),
        .i_tiles_x    (i_tiles_x),
        .i_tiles_y    (i_tiles_y),
        .i_tile_shift (i_tile_shift),
        .o_busy       (w_walk_busy),
        .o_tile_valid (w_tile_valid),
        .o_tile_x     (w_tile_x),
        .o_tile_y     (w_tile_y),
        .o_px         (w_px),
        .o_py         (w_py),
        .o_edge_a     (w_edge_a),
        .o_edge_b     (w_edge_b),
        .o_edge_c     (w_edge_c),
        .o_tile_shift (w_tile_shift)
    );

    edge_corner_eval #(.TAKE_MAX(1'b1)) tr_eval (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_stall      (w_stall),
        .i_tile_valid (w_tile_valid),
        .i_tile_x     (w_tile_x),
        .i_tile_y     (w_tile_y),
        .i_px         (w_px),
        .i_py         (w_py),
        .i_edge_a     (w_edge_a),
        .i_edge_b     (w_edge_b),
        .i_edge_c     (w_edge_c),
        .i_tile_shift (w_tile_shift),
        .o_valid      (w_tr_valid),
        .o_tile_x     (w_tr_tile_x),
        .o_tile_y     (w_tr_tile_y),
        .o_value      (w_tr_value)
    );

    // valid and index match tr_eval, left open
    edge_corner_eval #(.TAKE_MAX(1'b0)) ta_eval (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_stall      (w_stall),
        .i_tile_valid (w_tile_valid),
        .i_tile_x     (w_tile_x),
        .i_tile_y     (w_tile_y),
        .i_px         (w_px),
        .i_py         (w_py),
        .i_edge_a     (w_edge_a),
        .i_edge_b     (w_edge_b),
        .i_edge_c     (w_edge_c),
        .i_tile_shift (w_tile_shift),
        .o_valid      (),
        .o_tile_x     (),
        .o_tile_y     (),
        .o_value      (w_ta_value)
    );

    tile_classifier classifier_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_walk_busy    (w_walk_busy),
        .i_tr_valid     (w_tr_valid),
        .i_tr_value     (w_tr_value),
        .i_ta_value     (w_ta_value),
        .i_tile_x       (w_tr_tile_x),
        .i_tile_y       (w_tr_tile_y),
        .i_raster_full  (i_raster_full),
        .i_shader_full  (i_shader_full),
        .o_stall        (w_stall),
        .o_busy         (o_busy),
        .o_raster_write (o_raster_write),
        .o_shader_write (o_shader_write),
        .o_tile_x       (o_tile_x),
        .o_tile_y       (o_tile_y)
    );

endmodule

// ==== logic/edge_corner_eval.sv ====
/*
 * edge_corner_eval: all edge values at the TR corner (TAKE_MAX set)
 * or the TA corner (TAKE_MAX clear) of a tile, one register stage
 */
`include "binner_cfg.svh"

module edge_corner_eval #(
    parameter bit TAKE_MAX = 1'b1
) (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_stall,
    input  logic                     i_tile_valid,
    input  raster_geom_pkg::coord_t  i_tile_x,
    input  raster_geom_pkg::coord_t  i_tile_y,
    input  raster_geom_pkg::coord_t  i_px,
    input  raster_geom_pkg::coord_t  i_py,
    input  raster_geom_pkg::coef_t   i_edge_a [`BINNER_EDGE_N],
    input  raster_geom_pkg::coef_t   i_edge_b [`BINNER_EDGE_N],
    input  raster_geom_pkg::const_t  i_edge_c [`BINNER_EDGE_N],
    input  raster_geom_pkg::shift_t  i_tile_shift,
    output logic                     o_valid,
    output raster_geom_pkg::coord_t  o_tile_x,
    output raster_geom_pkg::coord_t  o_tile_y,
    output raster_geom_pkg::eval_t   o_value [`BINNER_EDGE_N]
);

    // one extra bit so the far corner of the last tile still fits
    logic [`BINNER_COORD_W:0]  w_size;
    logic [`BINNER_COORD_W:0]  w_cx [`BINNER_EDGE_N];
    logic [`BINNER_COORD_W:0]  w_cy [`BINNER_EDGE_N];
    logic [`BINNER_EDGE_N-1:0] w_far_x;
    logic [`BINNER_EDGE_N-1:0] w_far_y;
    raster_geom_pkg::eval_t    w_value [`BINNER_EDGE_N];

    assign w_size = (`BINNER_COORD_W+1)'(1) << i_tile_shift;

    always_comb begin
        for (int e = 0; e < `BINNER_EDGE_N; e++) begin
            // max corner lies toward positive coefficients, min corner opposite
            w_far_x[e] = TAKE_MAX ? (i_edge_a[e] >= 0) : (i_edge_a[e] < 0);
            w_far_y[e] = TAKE_MAX ? (i_edge_b[e] >= 0) : (i_edge_b[e] < 0);
            w_cx[e] = {1'b0, i_px} + (w_far_x[e] ? w_size : '0);
            w_cy[e] = {1'b0, i_py} + (w_far_y[e] ? w_size : '0);
            w_value[e] = i_edge_a[e] * raster_geom_pkg::eval_t'(w_cx[e])
                       + i_edge_b[e] * raster_geom_pkg::eval_t'(w_cy[e])
                       + raster_geom_pkg::eval_t'(i_edge_c[e]);
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else if (!i_stall) begin
            o_valid <= i_tile_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_tile_x <= i_tile_x;
            o_tile_y <= i_tile_y;
            o_value  <= w_value;
        end
    end

endmodule

// ==== logic/raster_geom_pkg.sv ====
/*
 * Geometry types for the binner
 * coordinates, edge coefficients, edge values and the tile shift
 */
`include "binner_cfg.svh"

package raster_geom_pkg;

    // unsigned tile index or pixel coordinate
    typedef logic [`BINNER_COORD_W-1:0] coord_t;

    // a and b terms of an edge equation
    typedef logic signed [`BINNER_COEF_W-1:0] coef_t;

    // c term of an edge equation
    typedef logic signed [`BINNER_CONST_W-1:0] const_t;

    // edge value at a corner, sign gives the side
    typedef logic signed [`BINNER_EVAL_W-1:0] eval_t;

    // tile size as a power of two
    typedef logic [`BINNER_SHIFT_W-1:0] shift_t;

endpackage

// ==== logic/tile_classifier.sv ====
/*
 * tile_classifier: TR/TA sign tests, output register for one tile,
 * raster and shader queue writes, stall and busy
 */
`include "binner_cfg.svh"

module tile_classifier (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_walk_busy,
    input  logic                     i_tr_valid,
    input  raster_geom_pkg::eval_t   i_tr_value [`BINNER_EDGE_N],
    input  raster_geom_pkg::eval_t   i_ta_value [`BINNER_EDGE_N],
    input  raster_geom_pkg::coord_t  i_tile_x,
    input  raster_geom_pkg::coord_t  i_tile_y,
    input  logic                     i_raster_full,
    input  logic                     i_shader_full,
    output logic                     o_stall,
    output logic                     o_busy,
    output logic                     o_raster_write,
    output logic                     o_shader_write,
    output raster_geom_pkg::coord_t  o_tile_x,
    output raster_geom_pkg::coord_t  o_tile_y
);

    binner_ctl_pkg::tile_class_e w_class;
    binner_ctl_pkg::tile_class_e r_class;
    logic                        r_valid;
    logic                        w_tr_neg;
    logic                        w_ta_pos;

    always_comb begin
        w_tr_neg = 1'b0;
        w_ta_pos = 1'b1;
        for (int e = 0; e < `BINNER_EDGE_N; e++) begin
            w_tr_neg = w_tr_neg | (i_tr_value[e] < 0);
            w_ta_pos = w_ta_pos & (i_ta_value[e] >= 0);
        end
        if (w_tr_neg) begin
            w_class = binner_ctl_pkg::TC_REJECT;
        end else if (w_ta_pos) begin
            w_class = binner_ctl_pkg::TC_FULL;
        end else begin
            w_class = binner_ctl_pkg::TC_PARTIAL;
        end
    end

    // a rejected tile sits here one cycle and is never written
    assign o_raster_write = r_valid && (r_class == binner_ctl_pkg::TC_PARTIAL) && !i_raster_full;
    assign o_shader_write = r_valid && (r_class == binner_ctl_pkg::TC_FULL) && !i_shader_full;

    assign o_stall = r_valid &&
                     (((r_class == binner_ctl_pkg::TC_PARTIAL) && i_raster_full) ||
                      ((r_class == binner_ctl_pkg::TC_FULL) && i_shader_full));

    assign o_busy = i_walk_busy || i_tr_valid || r_valid;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            r_valid <= 1'b0;
            r_class <= binner_ctl_pkg::TC_REJECT;
        end else if (!o_stall) begin
            r_valid <= i_tr_valid;
            r_class <= w_class;
        end
    end

    always_ff @(posedge clk) begin
        if (!o_stall) begin
            o_tile_x <= i_tile_x;
            o_tile_y <= i_tile_y;
        end
    end

    a_one_write: assert property (@(posedge clk) disable iff (i_rst)
        !(o_raster_write && o_shader_write));

    a_no_write_full: assert property (@(posedge clk) disable iff (i_rst)
        (i_raster_full |-> !o_raster_write) and (i_shader_full |-> !o_shader_write));

endmodule

// ==== logic/tile_walker.sv ====
/*
 * tile_walker: latches one triangle and its tile rectangle,
 * then issues tile indices and pixel origins in raster order
 */
`include "binner_cfg.svh"

module tile_walker (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_stall,
    input  logic                     i_valid,
    input  raster_geom_pkg::coef_t   i_edge_a [`BINNER_EDGE_N],
    input  raster_geom_pkg::coef_t   i_edge_b [`BINNER_EDGE_N],
    input  raster_geom_pkg::const_t  i_edge_c [`BINNER_EDGE_N],
    input  raster_geom_pkg::coord_t  i_min_tx,
    input  raster_geom_pkg::coord_t  i_min_ty,
    input  raster_geom_pkg::coord_t  i_tiles_x,
    input  raster_geom_pkg::coord_t  i_tiles_y,
    input  raster_geom_pkg::shift_t  i_tile_shift,
    output logic                     o_busy,
    output logic                     o_tile_valid,
    output raster_geom_pkg::coord_t  o_tile_x,
    output raster_geom_pkg::coord_t  o_tile_y,
    output raster_geom_pkg::coord_t  o_px,
    output raster_geom_pkg::coord_t  o_py,
    output raster_geom_pkg::coef_t   o_edge_a [`BINNER_EDGE_N],
    output raster_geom_pkg::coef_t   o_edge_b [`BINNER_EDGE_N],
    output raster_geom_pkg::const_t  o_edge_c [`BINNER_EDGE_N],
    output raster_geom_pkg::shift_t  o_tile_shift
);

    binner_ctl_pkg::walk_state_e r_state;
    raster_geom_pkg::coord_t     r_min_tx;
    raster_geom_pkg::coord_t     r_tiles_x;
    raster_geom_pkg::coord_t     r_tiles_y;
    raster_geom_pkg::coord_t     r_cnt_x;
    raster_geom_pkg::coord_t     r_cnt_y;
    logic                        r_drain;
    logic                        w_accept;
    logic                        w_last_x;
    logic                        w_last_y;

    // an empty rectangle has nothing to walk, so it is not taken
    assign w_accept = (r_state == binner_ctl_pkg::W_IDLE) && i_valid &&
                      (i_tiles_x != '0) && (i_tiles_y != '0);

    assign w_last_x = (r_cnt_x == r_tiles_x - 1'b1);
    assign w_last_y = (r_cnt_y == r_tiles_y - 1'b1);

    // one tile per cycle in W_STEP
    assign o_busy       = (r_state == binner_ctl_pkg::W_STEP);
    assign o_tile_valid = (r_state == binner_ctl_pkg::W_STEP);

    // tile origin in pixels
    assign o_px = o_tile_x << o_tile_shift;
    assign o_py = o_tile_y << o_tile_shift;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            r_state <= binner_ctl_pkg::W_IDLE;
            r_cnt_x <= '0;
            r_cnt_y <= '0;
            r_drain <= 1'b0;
        end else begin
            case (r_state)
                binner_ctl_pkg::W_IDLE: begin
                    if (w_accept) begin
                        r_state <= binner_ctl_pkg::W_STEP;
                        r_cnt_x <= '0;
                        r_cnt_y <= '0;
                    end
                end
                binner_ctl_pkg::W_STEP: begin
                    if (!i_stall) begin
                        if (w_last_x) begin
                            r_cnt_x <= '0;
                            if (w_last_y) begin
                                r_state <= binner_ctl_pkg::W_DRAIN;
                                r_drain <= 1'b0;
                            end else begin
                                r_cnt_y <= r_cnt_y + 1'b1;
                            end
                        end else begin
                            r_cnt_x <= r_cnt_x + 1'b1;
                        end
                    end
                end
                binner_ctl_pkg::W_DRAIN: begin
                    // last tile needs two moving cycles to leave the classifier
                    if (!i_stall) begin
                        if (r_drain) begin
                            r_state <= binner_ctl_pkg::W_IDLE;
                        end
                        r_drain <= !r_drain;
                    end
                end
                default: begin
                    r_state <= binner_ctl_pkg::W_IDLE;
                end
            endcase
        end
    end

    // triangle latch and tile index, x fastest
    always_ff @(posedge clk) begin
        if (w_accept) begin
            o_edge_a     <= i_edge_a;
            o_edge_b     <= i_edge_b;
            o_edge_c     <= i_edge_c;
            o_tile_shift <= i_tile_shift;
            r_min_tx     <= i_min_tx;
            r_tiles_x    <= i_tiles_x;
            r_tiles_y    <= i_tiles_y;
            o_tile_x     <= i_min_tx;
            o_tile_y     <= i_min_ty;
        end else if (o_busy && !i_stall) begin
            if (w_last_x) begin
                o_tile_x <= r_min_tx;
                if (!w_last_y) begin
                    o_tile_y <= o_tile_y + 1'b1;
                end
            end else begin
                o_tile_x <= o_tile_x + 1'b1;
            end
        end
    end

    a_cnt_in_range: assert property (@(posedge clk) disable iff (i_rst)
        o_busy |-> (r_cnt_x < r_tiles_x) && (r_cnt_y < r_tiles_y));

endmodule

// ==== tests/binner_tb.sv ====
/*
 * testbench for binner_top
 * reference tile classifier, write checker, back-pressure driver, watchdog
 */
`include "binner_cfg.svh"

module binner_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF = 20;
    localparam int STIM_DLY = 5;
    localparam int RANDOM_TRIS = 20;
    localparam int MAX_RAND_TILES = 64;
    // full, reject and busy-input tests use fixed rectangles
    localparam int MAX_TILES = 16 + 9 + 16 + 2 * RANDOM_TRIS * MAX_RAND_TILES;
    localparam int TIMEOUT_CYCLES = MAX_TILES * 4 + 200;

    logic                    clk = 1'b0;
    logic                    i_rst;
    logic                    i_valid;
    raster_geom_pkg::coef_t  i_edge_a [`BINNER_EDGE_N];
    raster_geom_pkg::coef_t  i_edge_b [`BINNER_EDGE_N];
    raster_geom_pkg::const_t i_edge_c [`BINNER_EDGE_N];
    raster_geom_pkg::coord_t i_min_tx;
    raster_geom_pkg::coord_t i_min_ty;
    raster_geom_pkg::coord_t i_tiles_x;
    raster_geom_pkg::coord_t i_tiles_y;
    raster_geom_pkg::shift_t i_tile_shift;
    logic                    i_raster_full;
    logic                    i_shader_full;
    logic                    o_busy;
    logic                    o_raster_write;
    logic                    o_shader_write;
    raster_geom_pkg::coord_t o_tile_x;
    raster_geom_pkg::coord_t o_tile_y;

    integer      seed = 32'hf704_dcf1;
    int          mismatches = 0;
    int          other_errors = 0;
    int          n_raster;
    int          n_shader;
    string       test_name = "init";
    logic        bp_en = 1'b0;
    // {full, tile x, tile y} in raster order
    logic [32:0] exp_q [$];
    logic [32:0] exp_item;

    binner_top binner_top_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_edge_a       (i_edge_a),
        .i_edge_b       (i_edge_b),
        .i_edge_c       (i_edge_c),
        .i_min_tx       (i_min_tx),
        .i_min_ty       (i_min_ty),
        .i_tiles_x      (i_tiles_x),
        .i_tiles_y      (i_tiles_y),
        .i_tile_shift   (i_tile_shift),
        .i_raster_full  (i_raster_full),
        .i_shader_full  (i_shader_full),
        .o_busy         (o_busy),
        .o_raster_write (o_raster_write),
        .o_shader_write (o_shader_write),
        .o_tile_x       (o_tile_x),
        .o_tile_y       (o_tile_y)
    );

    always #CLK_HALF clk = ~clk;

    task automatic compare_value(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual) begin
            mismatches++;
            $display("[ERROR] %s: %s expected %0h got %0h", test_name, what, expected, actual);
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    // TR corner maximizes each edge, TA corner is the opposite one
    function automatic binner_ctl_pkg::tile_class_e classify_tile(
        input raster_geom_pkg::coef_t  a [`BINNER_EDGE_N],
        input raster_geom_pkg::coef_t  b [`BINNER_EDGE_N],
        input raster_geom_pkg::const_t c [`BINNER_EDGE_N],
        input int tx,
        input int ty,
        input int shift
    );
        longint x0;
        longint x1;
        longint y0;
        longint y1;
        longint tr;
        longint ta;
        bit     any_tr_neg;
        bit     all_ta_pos;
        x0 = longint'(tx) << shift;
        y0 = longint'(ty) << shift;
        x1 = x0 + (longint'(1) << shift);
        y1 = y0 + (longint'(1) << shift);
        any_tr_neg = 1'b0;
        all_ta_pos = 1'b1;
        for (int e = 0; e < `BINNER_EDGE_N; e++) begin
            tr = a[e] * ((a[e] >= 0) ? x1 : x0) + b[e] * ((b[e] >= 0) ? y1 : y0) + c[e];
            ta = a[e] * ((a[e] >= 0) ? x0 : x1) + b[e] * ((b[e] >= 0) ? y0 : y1) + c[e];
            if (tr < 0) begin
                any_tr_neg = 1'b1;
            end
            if (ta < 0) begin
                all_ta_pos = 1'b0;
            end
        end
        if (any_tr_neg) begin
            return binner_ctl_pkg::TC_REJECT;
        end else if (all_ta_pos) begin
            return binner_ctl_pkg::TC_FULL;
        end
        return binner_ctl_pkg::TC_PARTIAL;
    endfunction

    task automatic build_expected();
        binner_ctl_pkg::tile_class_e cls;
        int                          tx;
        int                          ty;
        exp_q.delete();
        for (int j = 0; j < int'(i_tiles_y); j++) begin
            for (int i = 0; i < int'(i_tiles_x); i++) begin
                tx = int'(i_min_tx) + i;
                ty = int'(i_min_ty) + j;
                cls = classify_tile(i_edge_a, i_edge_b, i_edge_c, tx, ty, int'(i_tile_shift));
                if (cls != binner_ctl_pkg::TC_REJECT) begin
                    exp_q.push_back({cls == binner_ctl_pkg::TC_FULL,
                                     raster_geom_pkg::coord_t'(tx),
                                     raster_geom_pkg::coord_t'(ty)});
                end
            end
        end
    endtask

    task automatic next_drive_slot();
        @(posedge clk);
        #STIM_DLY;
    endtask

    task automatic set_rect(input int mtx, input int mty, input int nx, input int ny,
                            input int shift);
        i_min_tx     = raster_geom_pkg::coord_t'(mtx);
        i_min_ty     = raster_geom_pkg::coord_t'(mty);
        i_tiles_x    = raster_geom_pkg::coord_t'(nx);
        i_tiles_y    = raster_geom_pkg::coord_t'(ny);
        i_tile_shift = raster_geom_pkg::shift_t'(shift);
    endtask

    task automatic set_edge(input int e, input int a, input int b, input int c);
        i_edge_a[e] = raster_geom_pkg::coef_t'(a);
        i_edge_b[e] = raster_geom_pkg::coef_t'(b);
        i_edge_c[e] = raster_geom_pkg::const_t'(c);
    endtask

    task automatic set_random_triangle();
        int lo_x;
        int lo_y;
        int hi_x;
        int hi_y;
        int px;
        int py;
        set_rect(rand_range(0, 15), rand_range(0, 15), rand_range(1, 8), rand_range(1, 8),
                 rand_range(0, 6));
        lo_x = int'(i_min_tx) << i_tile_shift;
        lo_y = int'(i_min_ty) << i_tile_shift;
        hi_x = (int'(i_min_tx) + int'(i_tiles_x)) << i_tile_shift;
        hi_y = (int'(i_min_ty) + int'(i_tiles_y)) << i_tile_shift;
        for (int e = 0; e < `BINNER_EDGE_N; e++) begin
            // edge passes close to a random point of the rectangle
            px = rand_range(lo_x, hi_x);
            py = rand_range(lo_y, hi_y);
            i_edge_a[e] = raster_geom_pkg::coef_t'(rand_range(-64, 63));
            i_edge_b[e] = raster_geom_pkg::coef_t'(rand_range(-64, 63));
            i_edge_c[e] = raster_geom_pkg::const_t'(
                -(int'(i_edge_a[e]) * px + int'(i_edge_b[e]) * py) + rand_range(-32, 32));
        end
    endtask

    // called in a drive slot, returns at the negedge after acceptance
    task automatic start_triangle();
        build_expected();
        n_raster = 0;
        n_shader = 0;
        i_valid = 1'b1;
        next_drive_slot();
        i_valid = 1'b0;
        @(negedge clk);
        compare_value("o_busy after accept", 64'd1, 64'(o_busy));
    endtask

    task automatic finish_triangle();
        while (o_busy) begin
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%s: %0d expected writes never arrived", test_name, exp_q.size());
        end
    endtask

    // queue writes are checked mid-cycle where they are stable
    always @(negedge clk) begin
        if (!i_rst) begin
            compare_value("single write", 64'd0, 64'(o_raster_write && o_shader_write));
            compare_value("raster write while full", 64'd0,
                          64'(o_raster_write && i_raster_full));
            compare_value("shader write while full", 64'd0,
                          64'(o_shader_write && i_shader_full));
            if (o_raster_write || o_shader_write) begin
                if (o_raster_write) begin
                    n_raster++;
                end else begin
                    n_shader++;
                end
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("%s: write of tile (%0d,%0d) when no write was expected",
                             test_name, o_tile_x, o_tile_y);
                end else begin
                    exp_item = exp_q.pop_front();
                    compare_value("queue kind", 64'(exp_item[32]), 64'(o_shader_write));
                    compare_value("tile x", 64'(exp_item[31:16]), 64'(o_tile_x));
                    compare_value("tile y", 64'(exp_item[15:0]), 64'(o_tile_y));
                end
            end
        end
    end

    // random queue back-pressure
    always @(posedge clk) begin
        #STIM_DLY;
        if (bp_en) begin
            i_raster_full = (rand_range(0, 1) == 1);
            i_shader_full = (rand_range(0, 1) == 1);
        end else begin
            i_raster_full = 1'b0;
            i_shader_full = 1'b0;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        i_rst   = 1'b1;
        i_valid = 1'b0;
        i_raster_full = 1'b0;
        i_shader_full = 1'b0;
        set_rect(0, 0, 1, 1, 0);
        for (int e = 0; e < `BINNER_EDGE_N; e++) begin
            set_edge(e, 0, 0, 0);
        end
        repeat (10) @(posedge clk);
        #STIM_DLY;
        i_rst = 1'b0;

        test_name = "after_reset";
        repeat (5) begin
            @(negedge clk);
            compare_value("o_busy", 64'd0, 64'(o_busy));
            compare_value("o_raster_write", 64'd0, 64'(o_raster_write));
            compare_value("o_shader_write", 64'd0, 64'(o_shader_write));
        end

        test_name = "full_coverage";
        next_drive_slot();
        set_rect(0, 0, 4, 4, 3);
        set_edge(0, 1, 0, 10);
        set_edge(1, 0, 1, 10);
        set_edge(2, -1, -1, 200);
        start_triangle();
        finish_triangle();
        compare_value("shader writes", 64'd16, 64'(n_shader));
        compare_value("raster writes", 64'd0, 64'(n_raster));

        test_name = "full_rejection";
        next_drive_slot();
        set_rect(2, 2, 3, 3, 2);
        set_edge(0, 1, 0, -100);
        set_edge(1, 0, 1, -100);
        set_edge(2, -1, -1, 1000);
        start_triangle();
        finish_triangle();
        compare_value("shader writes", 64'd0, 64'(n_shader));
        compare_value("raster writes", 64'd0, 64'(n_raster));

        for (int t = 0; t < RANDOM_TRIS; t++) begin
            test_name = $sformatf("mixed_%0d", t);
            next_drive_slot();
            set_random_triangle();
            start_triangle();
            finish_triangle();
        end

        bp_en = 1'b1;
        for (int t = 0; t < RANDOM_TRIS; t++) begin
            test_name = $sformatf("backpressure_%0d", t);
            next_drive_slot();
            set_random_triangle();
            start_triangle();
            finish_triangle();
        end
        bp_en = 1'b0;

        test_name = "input_while_busy";
        next_drive_slot();
        set_rect(1, 1, 4, 4, 3);
        set_edge(0, 1, 0, -12);
        set_edge(1, 0, 1, -12);
        set_edge(2, -1, -1, 70);
        start_triangle();
        next_drive_slot();
        next_drive_slot();
        // a fully covered triangle on other tiles, it must not be taken
        set_rect(30, 30, 2, 2, 2);
        set_edge(0, 0, 0, 1);
        set_edge(1, 0, 0, 1);
        set_edge(2, 0, 0, 1);
        if (!o_busy) begin
            other_errors++;
            $display("%s: o_busy dropped before the second valid", test_name);
        end
        i_valid = 1'b1;
        next_drive_slot();
        i_valid = 1'b0;
        finish_triangle();
        repeat (4) begin
            @(negedge clk);
            compare_value("o_busy after walk", 64'd0, 64'(o_busy));
        end

        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if ((mismatches + other_errors) == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/raster_geom_pkg.sv
logic/binner_ctl_pkg.sv
logic/tile_walker.sv
logic/edge_corner_eval.sv
logic/tile_classifier.sv
logic/binner_top.sv
tests/binner_tb.sv
